//--- source/ram_config.svh
`default_nettype none

`ifndef RAM_CONFIG_SVH
`define RAM_CONFIG_SVH

// bus widths
`define RAM_ADDR_WIDTH 32
`define RAM_DATA_WIDTH 32
`define RAM_STRB_WIDTH 4

// word index bits, 1024 words of 4 bytes
`define RAM_WORD_BITS 10

// quiet cycles before the RAM counts as idle
`define RAM_IDLE_LIMIT 4095
`define RAM_IDLE_WIDTH 12

`endif

`default_nettype wire

//--- source/axi_ram_pkg.sv
`include "ram_config.svh"

`default_nettype none

package axi_ram_pkg;

    // AXI response codes, EXOKAY is never produced here
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // one address word: plain byte address or region / word / byte offset
    typedef union packed {
        logic [`RAM_ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [`RAM_ADDR_WIDTH-`RAM_WORD_BITS-$clog2(`RAM_STRB_WIDTH)-1:0] region;
            logic [`RAM_WORD_BITS-1:0]                                       word;
            logic [$clog2(`RAM_STRB_WIDTH)-1:0]                              offset;
        } field;
    } ram_addr_u;

endpackage

`default_nettype wire

//--- source/axi_if.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

interface axi_if
    import axi_ram_pkg::*;
();

    // write address
    logic                       aw_valid;
    logic                       aw_ready;
    ram_addr_u                  aw_addr;

    // write data, single beat
    logic                       w_valid;
    logic                       w_ready;
    logic [`RAM_DATA_WIDTH-1:0] w_data;
    logic [`RAM_STRB_WIDTH-1:0] w_strb;

    // write response
    logic                       b_valid;
    logic                       b_ready;
    axi_resp_t                  b_resp;

    // read address
    logic                       ar_valid;
    logic                       ar_ready;
    ram_addr_u                  ar_addr;

    // read data
    logic                       r_valid;
    logic                       r_ready;
    logic [`RAM_DATA_WIDTH-1:0] r_data;
    axi_resp_t                  r_resp;

    modport master (
        output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        output ar_valid, ar_addr, r_ready,
        input  aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
    );

    modport slave (
        input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        input  ar_valid, ar_addr, r_ready,
        output aw_ready, w_ready, b_valid, b_resp, ar_ready, r_valid, r_data, r_resp
    );

endinterface

`default_nettype wire

//--- source/axi_bus_master.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

module axi_bus_master
    import axi_ram_pkg::*;
(
    input  logic                       clock0,
    input  logic                       reset,
    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  ram_addr_u                  cmd_addr,
    input  logic [`RAM_DATA_WIDTH-1:0] cmd_wdata,
    input  logic [`RAM_STRB_WIDTH-1:0] cmd_strb,
    output logic                       cmd_ready,
    output logic                       rsp_valid,
    output logic [`RAM_DATA_WIDTH-1:0] rsp_rdata,
    output axi_resp_t                  rsp_resp,
    axi_if.master                      bus
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_RESP = 2'd3;

    logic [1:0]                 state;
    logic                       write_q;
    ram_addr_u                  addr_q;
    logic [`RAM_DATA_WIDTH-1:0] wdata_q;
    logic [`RAM_STRB_WIDTH-1:0] strb_q;
    logic                       aw_valid_q;
    logic                       w_valid_q;
    logic                       ar_valid_q;
    logic                       cmd_take;
    logic                       aw_done;
    logic                       w_done;
    logic                       ar_done;
    logic                       b_take;
    logic                       r_take;

    assign cmd_take = cmd_valid && cmd_ready;
    // done once the valid has dropped or the transfer happens now
    assign aw_done  = !aw_valid_q || bus.aw_ready;
    assign w_done   = !w_valid_q || bus.w_ready;
    assign ar_done  = !ar_valid_q || bus.ar_ready;
    assign b_take   = bus.b_valid && bus.b_ready;
    assign r_take   = bus.r_valid && bus.r_ready;

    assign bus.aw_valid = aw_valid_q;
    assign bus.aw_addr  = addr_q;
    assign bus.w_valid  = w_valid_q;
    assign bus.w_data   = wdata_q;
    assign bus.w_strb   = strb_q;
    assign bus.ar_valid = ar_valid_q;
    assign bus.ar_addr  = addr_q;
    assign bus.b_ready  = (state == ST_WAIT) && write_q;
    assign bus.r_ready  = (state == ST_WAIT) && !write_q;
    assign rsp_valid    = (state == ST_RESP);

    always_ff @(posedge clock0) begin
        if (reset) begin
            state      <= ST_IDLE;
            cmd_ready  <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            ar_valid_q <= 1'b0;
        end else begin
            case (state)
                // respond also takes the next command
                ST_IDLE, ST_RESP: begin
                    cmd_ready <= !cmd_take;
                    if (cmd_take) begin
                        state      <= ST_ADDR;
                        aw_valid_q <= cmd_write;
                        w_valid_q  <= cmd_write;
                        ar_valid_q <= !cmd_write;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_ADDR: begin
                    if (aw_valid_q && bus.aw_ready) begin
                        aw_valid_q <= 1'b0;
                    end
                    if (w_valid_q && bus.w_ready) begin
                        w_valid_q <= 1'b0;
                    end
                    if (ar_valid_q && bus.ar_ready) begin
                        ar_valid_q <= 1'b0;
                    end
                    if (aw_done && w_done && ar_done) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (b_take || r_take) begin
                        state     <= ST_RESP;
                        cmd_ready <= 1'b1;
                    end
                end
            endcase
        end
    end

    // command and response payload
    always_ff @(posedge clock0) begin
        if (cmd_take) begin
            write_q <= cmd_write;
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
            strb_q  <= cmd_strb;
        end
        if (b_take) begin
            rsp_rdata <= '0;
            rsp_resp  <= bus.b_resp;
        end else if (r_take) begin
            rsp_rdata <= bus.r_data;
            rsp_resp  <= bus.r_resp;
        end
    end

endmodule

`default_nettype wire

//--- source/axi_interconnect_slice.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

module axi_interconnect_slice
    import axi_ram_pkg::*;
(
    input  logic  clock0,
    input  logic  reset,
    axi_if.slave  up,
    axi_if.master down
);

    logic                       aw_full, w_full, b_full, ar_full, r_full;
    logic                       aw_miss;
    ram_addr_u                  aw_addr_q;
    ram_addr_u                  ar_addr_q;
    logic [`RAM_DATA_WIDTH-1:0] w_data_q;
    logic [`RAM_STRB_WIDTH-1:0] w_strb_q;
    logic [`RAM_DATA_WIDTH-1:0] r_data_q;
    axi_resp_t                  b_resp_q;
    axi_resp_t                  r_resp_q;
    logic                       aw_in_miss, ar_in_miss;
    logic                       aw_take, w_take, ar_take;
    logic                       aw_leave, w_leave, ar_leave;
    logic                       b_space, r_space, ar_space;
    logic                       down_b_take, down_r_take;
    logic                       err_b_fire, err_r_fire;

    // anything outside region zero misses the RAM
    assign aw_in_miss = (up.aw_addr.field.region != '0);
    assign ar_in_miss = (up.ar_addr.field.region != '0);

    // return stages, ready when empty or draining this cycle
    assign b_space = !b_full || up.b_ready;
    assign r_space = !r_full || up.r_ready;

    // error responder takes a held miss AW together with its W beat
    assign err_b_fire = aw_full && aw_miss && w_full && b_space;
    assign err_r_fire = up.ar_valid && ar_in_miss && r_space;

    // write address stage
    assign down.aw_valid = aw_full && !aw_miss;
    assign down.aw_addr  = aw_addr_q;
    assign aw_leave      = (down.aw_valid && down.aw_ready) || err_b_fire;
    assign up.aw_ready   = !aw_full || aw_leave;
    assign aw_take       = up.aw_valid && up.aw_ready;

    // W follows the AW of the same transaction
    assign down.w_valid = w_full && !(aw_full && aw_miss);
    assign down.w_data  = w_data_q;
    assign down.w_strb  = w_strb_q;
    assign w_leave      = (down.w_valid && down.w_ready) || err_b_fire;
    assign up.w_ready   = !w_full || w_leave;
    assign w_take       = up.w_valid && up.w_ready;

    // write response stage
    assign down.b_ready = b_space && !err_b_fire;
    assign down_b_take  = down.b_valid && down.b_ready;
    assign up.b_valid   = b_full;
    assign up.b_resp    = b_resp_q;

    // read address stage, a miss goes straight to the R stage
    assign down.ar_valid = ar_full;
    assign down.ar_addr  = ar_addr_q;
    assign ar_leave      = ar_full && down.ar_ready;
    assign ar_space      = !ar_full || ar_leave;
    assign up.ar_ready   = ar_in_miss ? r_space : ar_space;
    assign ar_take       = up.ar_valid && !ar_in_miss && ar_space;

    // read data stage
    assign down.r_ready = r_space && !err_r_fire;
    assign down_r_take  = down.r_valid && down.r_ready;
    assign up.r_valid   = r_full;
    assign up.r_data    = r_data_q;
    assign up.r_resp    = r_resp_q;

    always_ff @(posedge clock0) begin
        if (reset) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            b_full  <= 1'b0;
            ar_full <= 1'b0;
            r_full  <= 1'b0;
        end else begin
            if (aw_take) begin
                aw_full <= 1'b1;
            end else if (aw_leave) begin
                aw_full <= 1'b0;
            end
            if (w_take) begin
                w_full <= 1'b1;
            end else if (w_leave) begin
                w_full <= 1'b0;
            end
            if (err_b_fire || down_b_take) begin
                b_full <= 1'b1;
            end else if (up.b_ready) begin
                b_full <= 1'b0;
            end
            if (ar_take) begin
                ar_full <= 1'b1;
            end else if (ar_leave) begin
                ar_full <= 1'b0;
            end
            if (err_r_fire || down_r_take) begin
                r_full <= 1'b1;
            end else if (up.r_ready) begin
                r_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock0) begin
        if (aw_take) begin
            aw_addr_q <= up.aw_addr;
            aw_miss   <= aw_in_miss;
        end
        if (w_take) begin
            w_data_q <= up.w_data;
            w_strb_q <= up.w_strb;
        end
        if (ar_take) begin
            ar_addr_q <= up.ar_addr;
        end
        if (err_b_fire) begin
            b_resp_q <= DECERR;
        end else if (down_b_take) begin
            b_resp_q <= down.b_resp;
        end
        if (err_r_fire) begin
            r_data_q <= '0;
            r_resp_q <= DECERR;
        end else if (down_r_take) begin
            r_data_q <= down.r_data;
            r_resp_q <= down.r_resp;
        end
    end

endmodule

`default_nettype wire

//--- source/axi_ram_peripheral.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

module axi_ram_peripheral
    import axi_ram_pkg::*;
(
    input  logic                       clock0,
    input  logic                       reset,
    axi_if.slave                       bus,
    input  logic                       debug_rd_en,
    input  ram_addr_u                  debug_rd_addr,
    output logic [`RAM_DATA_WIDTH-1:0] debug_rd_data,
    output logic                       busy
);

    logic [`RAM_DATA_WIDTH-1:0] mem [0:(1 << `RAM_WORD_BITS)-1];
    logic [`RAM_DATA_WIDTH-1:0] r_data_q;
    logic                       b_pending;
    logic                       r_pending;
    logic                       wr_take;
    logic                       rd_take;

    // AW and W go in together, one B outstanding at most
    assign bus.aw_ready = bus.w_valid && !b_pending;
    assign bus.w_ready  = bus.aw_valid && !b_pending;
    assign wr_take      = bus.aw_valid && bus.w_valid && !b_pending;
    assign bus.b_valid  = b_pending;
    assign bus.b_resp   = OKAY;

    assign bus.ar_ready = !r_pending;
    assign rd_take      = bus.ar_valid && !r_pending;
    assign bus.r_valid  = r_pending;
    assign bus.r_data   = r_data_q;
    assign bus.r_resp   = OKAY;

    assign busy = bus.aw_valid || bus.w_valid || bus.ar_valid || b_pending || r_pending;

    always_ff @(posedge clock0) begin
        if (reset) begin
            b_pending <= 1'b0;
            r_pending <= 1'b0;
        end else begin
            if (wr_take) begin
                b_pending <= 1'b1;
            end else if (bus.b_ready) begin
                b_pending <= 1'b0;
            end
            if (rd_take) begin
                r_pending <= 1'b1;
            end else if (bus.r_ready) begin
                r_pending <= 1'b0;
            end
        end
    end

    // byte lane merge under the strobes
    always_ff @(posedge clock0) begin
        if (wr_take) begin
            for (int i = 0; i < `RAM_STRB_WIDTH; i++) begin
                if (bus.w_strb[i]) begin
                    mem[bus.aw_addr.field.word][8*i +: 8] <= bus.w_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock0) begin
        if (rd_take) begin
            r_data_q <= mem[bus.ar_addr.field.word];
        end
    end

    // debug port, independent of the bus
    always_ff @(posedge clock0) begin
        if (debug_rd_en) begin
            debug_rd_data <= mem[debug_rd_addr.field.word];
        end
    end

endmodule

`default_nettype wire

//--- source/idle_monitor.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

module idle_monitor (
    input  logic clock0,
    input  logic reset,
    input  logic busy,
    output logic idle
);

    logic [`RAM_IDLE_WIDTH-1:0] quiet_count;

    // counts quiet cycles, holds at the limit
    always_ff @(posedge clock0) begin
        if (reset) begin
            quiet_count <= '0;
        end else if (busy) begin
            quiet_count <= '0;
        end else if (quiet_count != `RAM_IDLE_WIDTH'(`RAM_IDLE_LIMIT)) begin
            quiet_count <= quiet_count + 1'b1;
        end
    end

    assign idle = (quiet_count == `RAM_IDLE_WIDTH'(`RAM_IDLE_LIMIT));

endmodule

`default_nettype wire

//--- source/periph_ram_soc.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

module periph_ram_soc
    import axi_ram_pkg::*;
(
    input  logic                       clock0,
    input  logic                       reset,
    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  ram_addr_u                  cmd_addr,
    input  logic [`RAM_DATA_WIDTH-1:0] cmd_wdata,
    input  logic [`RAM_STRB_WIDTH-1:0] cmd_strb,
    output logic                       cmd_ready,
    output logic                       rsp_valid,
    output logic [`RAM_DATA_WIDTH-1:0] rsp_rdata,
    output axi_resp_t                  rsp_resp,
    input  logic                       debug_rd_en,
    input  ram_addr_u                  debug_rd_addr,
    output logic [`RAM_DATA_WIDTH-1:0] debug_rd_data,
    output logic                       mem_idle
);

    logic ram_busy;

    // master side and RAM side of the slice
    axi_if bus_m ();
    axi_if bus_s ();

    axi_bus_master u_master (
        .clock0    (clock0),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_strb  (cmd_strb),
        .cmd_ready (cmd_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_resp  (rsp_resp),
        .bus       (bus_m.master)
    );

    axi_interconnect_slice u_slice (
        .clock0 (clock0),
        .reset  (reset),
        .up     (bus_m.slave),
        .down   (bus_s.master)
    );

    axi_ram_peripheral u_ram (
        .clock0        (clock0),
        .reset         (reset),
        .bus           (bus_s.slave),
        .debug_rd_en   (debug_rd_en),
        .debug_rd_addr (debug_rd_addr),
        .debug_rd_data (debug_rd_data),
        .busy          (ram_busy)
    );

    idle_monitor u_idle (
        .clock0 (clock0),
        .reset  (reset),
        .busy   (ram_busy),
        .idle   (mem_idle)
    );

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

module tb_checker
    import axi_ram_pkg::*;
(
    input  logic                       clock0,
    input  logic                       reset,
    input  logic                       cmd_valid,
    input  logic                       cmd_ready,
    input  logic                       rsp_valid,
    input  logic [`RAM_DATA_WIDTH-1:0] rsp_rdata,
    input  axi_resp_t                  rsp_resp,
    input  logic                       mem_idle,
    input  logic                       debug_rd_en,
    input  logic [`RAM_DATA_WIDTH-1:0] debug_rd_data,
    input  logic                       exp_push,
    input  logic [`RAM_DATA_WIDTH-1:0] exp_data,
    input  axi_resp_t                  exp_resp,
    input  logic [`RAM_DATA_WIDTH-1:0] dbg_expect,
    input  logic                       idle_check,
    input  logic                       idle_expect,
    output int                         check_count,
    output int                         error_count,
    output int                         pending
);

    typedef struct packed {
        logic [`RAM_DATA_WIDTH-1:0] data;
        axi_resp_t                  resp;
    } rsp_expect_t;

    rsp_expect_t                exp_q[$];
    rsp_expect_t                entry;
    rsp_expect_t                head;
    logic                       dbg_armed = 1'b0;
    logic [`RAM_DATA_WIDTH-1:0] dbg_value = '0;
    logic                       cmd_open = 1'b0;
    int                         checks = 0;
    int                         errors = 0;
    int                         pending_n = 0;

    assign check_count = checks;
    assign error_count = errors;
    assign pending     = pending_n;

    // outputs are stable at the falling edge
    always @(negedge clock0) begin
        if (reset) begin
            dbg_armed = 1'b0;
            cmd_open  = 1'b0;
        end else begin
            if (exp_push) begin
                entry.data = exp_data;
                entry.resp = exp_resp;
                exp_q.push_back(entry);
            end
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response at %0t arrived with no command outstanding", $time);
                end else begin
                    head = exp_q.pop_front();
                    checks++;
                    if (rsp_resp !== head.resp || rsp_rdata !== head.data) begin
                        errors++;
                        $display("FAIL %0t: response %h %s, expected %h %s", $time,
                                 rsp_rdata, rsp_resp.name(), head.data, head.resp.name());
                    end
                    if (mem_idle !== 1'b0) begin
                        errors++;
                        $display("FAIL %0t: mem_idle high during a response", $time);
                    end
                end
            end
            // a command stays open until its response
            if (rsp_valid) begin
                cmd_open = 1'b0;
            end
            if (cmd_open && cmd_ready !== 1'b0) begin
                errors++;
                $display("FAIL %0t: cmd_ready high while a command is open", $time);
            end
            if (cmd_valid && cmd_ready) begin
                cmd_open = 1'b1;
            end
            // debug data shows up one cycle after the enable
            if (dbg_armed) begin
                checks++;
                if (debug_rd_data !== dbg_value) begin
                    errors++;
                    $display("FAIL %0t: debug read %h, expected %h", $time,
                             debug_rd_data, dbg_value);
                end
            end
            dbg_armed = debug_rd_en;
            dbg_value = dbg_expect;
            if (idle_check) begin
                checks++;
                if (mem_idle !== idle_expect) begin
                    errors++;
                    $display("FAIL %0t: mem_idle is %b, expected %b", $time,
                             mem_idle, idle_expect);
                end
            end
            pending_n = exp_q.size();
        end
    end

endmodule

`default_nettype wire

//--- test/tb_periph_ram_soc.sv
`include "ram_config.svh"

`timescale 1ns/10ps
`default_nettype none

module tb_periph_ram_soc
    import axi_ram_pkg::*;
();

    localparam int RANDOM_COUNT = 200;
    // random commands need under 40 cycles each, plus the 4115-cycle idle wait
    localparam int TIMEOUT_CYCLES = 20000;

    logic                       clock0;
    logic                       reset;
    logic                       cmd_valid;
    logic                       cmd_write;
    ram_addr_u                  cmd_addr;
    logic [`RAM_DATA_WIDTH-1:0] cmd_wdata;
    logic [`RAM_STRB_WIDTH-1:0] cmd_strb;
    logic                       cmd_ready;
    logic                       rsp_valid;
    logic [`RAM_DATA_WIDTH-1:0] rsp_rdata;
    axi_resp_t                  rsp_resp;
    logic                       debug_rd_en;
    ram_addr_u                  debug_rd_addr;
    logic [`RAM_DATA_WIDTH-1:0] debug_rd_data;
    logic                       mem_idle;
    logic                       exp_push;
    logic [`RAM_DATA_WIDTH-1:0] exp_data;
    axi_resp_t                  exp_resp;
    logic [`RAM_DATA_WIDTH-1:0] dbg_expect;
    logic                       idle_check;
    logic                       idle_expect;
    int                         check_count;
    int                         error_count;
    int                         pending;
    int                         seed = 49791;
    int                         cycle_count = 0;
    int                         mark = 0;
    logic [31:0]                model [0:(1 << `RAM_WORD_BITS)-1];
    logic [31:0]                r;
    logic [31:0]                d;
    logic [31:0]                s;

    periph_ram_soc u_periph_ram_soc (.*);

    tb_checker u_checker (.*);

    initial begin
        clock0 = 1'b0;
        forever #5 clock0 = ~clock0;
    end

    always @(posedge clock0) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // merged word under the strobes, DECERR outside region zero
    function automatic axi_resp_t reference_access(input logic [31:0] addr,
                                                   input logic [31:0] old_word,
                                                   input logic [31:0] new_data,
                                                   input logic [3:0] strb,
                                                   output logic [31:0] merged);
        merged = old_word;
        if (addr[31:12] != 20'd0) begin
            return DECERR;
        end
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_data[8*i +: 8];
            end
        end
        return OKAY;
    endfunction

    task automatic send_cmd(input logic write, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        logic [9:0]  idx;
        logic [31:0] merged;
        logic [31:0] want_data;
        axi_resp_t   want_resp;
        idx = addr[11:2];
        want_resp = reference_access(addr, model[idx], data, write ? strb : 4'b0000, merged);
        if (write) begin
            if (want_resp == OKAY) begin
                model[idx] = merged;
            end
            want_data = '0;
        end else begin
            want_data = (want_resp == OKAY) ? model[idx] : '0;
        end
        @(posedge clock0);
        cmd_valid <= 1'b1;
        cmd_write <= write;
        cmd_addr  <= addr;
        cmd_wdata <= data;
        cmd_strb  <= strb;
        do @(negedge clock0); while (!cmd_ready);
        @(posedge clock0);
        cmd_valid <= 1'b0;
        exp_push  <= 1'b1;
        exp_data  <= want_data;
        exp_resp  <= want_resp;
        @(posedge clock0);
        exp_push  <= 1'b0;
    endtask

    task automatic wait_drain();
        do @(negedge clock0); while (pending != 0);
        @(posedge clock0);
    endtask

    task automatic debug_read(input logic [31:0] addr);
        @(posedge clock0);
        debug_rd_en   <= 1'b1;
        debug_rd_addr <= addr;
        dbg_expect    <= model[addr[11:2]];
        @(posedge clock0);
        debug_rd_en   <= 1'b0;
        @(posedge clock0);
    endtask

    task automatic check_idle_level(input logic level);
        @(posedge clock0);
        idle_check  <= 1'b1;
        idle_expect <= level;
        @(posedge clock0);
        idle_check  <= 1'b0;
    endtask

    task automatic report_test(input string name);
        wait_drain();
        $display("test %s: %0d errors", name, error_count - mark);
        mark = error_count;
    endtask

    initial begin
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr = '0;
        cmd_wdata = '0;
        cmd_strb = '0;
        debug_rd_en = 1'b0;
        debug_rd_addr = '0;
        exp_push = 1'b0;
        exp_data = '0;
        exp_resp = OKAY;
        dbg_expect = '0;
        idle_check = 1'b0;
        idle_expect = 1'b0;
        repeat (3) @(posedge clock0);
        reset <= 1'b0;

        send_cmd(1'b1, 32'h0000_0000, 32'hdead_beef, 4'hf);
        send_cmd(1'b1, 32'h0000_0004, 32'h0123_4567, 4'hf);
        send_cmd(1'b1, 32'h0000_0040, 32'h89ab_cdef, 4'hf);
        send_cmd(1'b1, 32'h0000_00fc, 32'h5a5a_a5a5, 4'hf);
        send_cmd(1'b0, 32'h0000_0000, '0, 4'h0);
        send_cmd(1'b0, 32'h0000_0004, '0, 4'h0);
        send_cmd(1'b0, 32'h0000_0040, '0, 4'h0);
        send_cmd(1'b0, 32'h0000_00fc, '0, 4'h0);
        report_test("full word write and read");

        send_cmd(1'b1, 32'h0000_0008, 32'h1122_3344, 4'hf);
        send_cmd(1'b1, 32'h0000_0008, 32'haabb_ccdd, 4'b0101);
        send_cmd(1'b1, 32'h0000_0040, 32'h7700_0000, 4'b1000);
        send_cmd(1'b0, 32'h0000_0008, '0, 4'h0);
        send_cmd(1'b0, 32'h0000_0040, '0, 4'h0);
        report_test("partial strobe");

        // region 0x10 aliases word 1 if the decode is wrong
        send_cmd(1'b1, 32'h0001_0004, 32'hffff_ffff, 4'hf);
        send_cmd(1'b0, 32'h0001_0004, '0, 4'h0);
        send_cmd(1'b0, 32'hffff_f0fc, '0, 4'h0);
        send_cmd(1'b0, 32'h0000_0004, '0, 4'h0);
        report_test("decode error");

        debug_read(32'h0000_0000);
        debug_read(32'h0000_0004);
        debug_read(32'h0000_0008);
        debug_read(32'h0000_0040);
        report_test("debug read");

        repeat (`RAM_IDLE_LIMIT + 20) @(posedge clock0);
        check_idle_level(1'b1);
        send_cmd(1'b0, 32'h0000_0004, '0, 4'h0);
        check_idle_level(1'b0);
        report_test("idle monitor");

        // known contents in the whole window first
        for (int w = 0; w < 64; w++) begin
            d = $random(seed);
            send_cmd(1'b1, {20'd0, 4'd0, w[5:0], 2'b00}, d, 4'hf);
        end
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            r = $random(seed);
            d = $random(seed);
            s = $random(seed);
            if (r[11:8] == 4'hf) begin
                send_cmd(r[6], {r[31:12] | 20'd1, 4'd0, r[5:0], 2'b00}, d, s[3:0]);
            end else begin
                send_cmd(r[6], {20'd0, 4'd0, r[5:0], 2'b00}, d, s[3:0]);
            end
            repeat (s[5:4]) @(posedge clock0);
        end
        report_test("random traffic");

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- periph_ram_soc.f
+incdir+source
source/axi_ram_pkg.sv
source/axi_if.sv
source/axi_bus_master.sv
source/axi_interconnect_slice.sv
source/axi_ram_peripheral.sv
source/idle_monitor.sv
source/periph_ram_soc.sv
test/tb_checker.sv
test/tb_periph_ram_soc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tb_periph_ram_soc \
    -f periph_ram_soc.f \
    -o sim_periph_ram_soc
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_periph_ram_soc)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "simulation reported a failure"
exit 1
